//--- source/CorePkg.sv
package CorePkg;

    // Program-order sequence number. It wraps, so compare it only with isOlder.
    typedef logic [5:0] SeqNum;

    // Physical destination tag. Tag 0 means the micro-op writes no register.
    typedef logic [5:0] RegTag;

    typedef logic [31:0] Word;

    localparam int NumUnits = 2;

    // True when a is older than b in program order. The difference is read as
    // a signed value, so this holds across the wrap from the highest number to 0.
    function automatic logic isOlder(SeqNum a, SeqNum b);
        SeqNum diff;
        diff = a - b;
        return diff[$bits(SeqNum)-1];
    endfunction

endpackage

//--- source/AluPkg.sv
package AluPkg;

    typedef logic [3:0] AluOp;

    localparam AluOp OpAdd  = 4'd0;
    localparam AluOp OpSub  = 4'd1;
    localparam AluOp OpAnd  = 4'd2;
    localparam AluOp OpOr   = 4'd3;
    localparam AluOp OpXor  = 4'd4;
    localparam AluOp OpSll  = 4'd5;
    localparam AluOp OpSrl  = 4'd6;
    localparam AluOp OpSra  = 4'd7;
    localparam AluOp OpSlt  = 4'd8;
    localparam AluOp OpSltu = 4'd9;

    // Compare branches and the unconditional jump.
    localparam AluOp OpBeq  = 4'd10;
    localparam AluOp OpBne  = 4'd11;
    localparam AluOp OpBlt  = 4'd12;
    localparam AluOp OpBge  = 4'd13;
    localparam AluOp OpBltu = 4'd14;
    localparam AluOp OpJal  = 4'd15;

    // Step from one instruction to the next in program order.
    localparam int InstrBytes = 4;

endpackage

//--- source/ExecResultIf.sv
`timescale 1ns/1ps

// One integer unit's finished micro-op as seen by the branch arbiter.
interface ExecResultIf import CorePkg::*; ();

    // One-cycle pulse per finished micro-op.
    logic  valid;
    RegTag tag;
    Word   result;
    SeqNum sqN;

    // Branch outcome. Only meaningful while valid is high.
    logic  mispred;
    Word   targetPc;

    modport unit (
        output valid,
        output tag,
        output result,
        output sqN,
        output mispred,
        output targetPc
    );

    modport arbiter (
        input valid,
        input tag,
        input result,
        input sqN,
        input mispred,
        input targetPc
    );

endinterface

//--- source/IntAlu.sv
`timescale 1ns/1ps

module IntAlu import CorePkg::*, AluPkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  logic  issueValid,
    input  AluOp  op,
    input  Word   srcA,
    input  Word   srcB,
    input  Word   imm,
    input  Word   pc,
    input  logic  predTaken,
    input  RegTag tag,
    input  SeqNum sqN,

    input  logic  flushValid,
    input  SeqNum flushSqN,

    ExecResultIf.unit res
);

    // Issue register. The micro-op is captured here and executed one cycle later.
    logic  exValid;
    AluOp  exOp;
    Word   exSrcA;
    Word   exSrcB;
    Word   exImm;
    Word   exPc;
    logic  exPredTaken;
    RegTag exTag;
    SeqNum exSqN;

    logic issueFlushed;
    logic exFlushed;

    Word  aluResult;
    logic isBranch;
    logic taken;
    Word  fallThrough;
    Word  branchTarget;

    // A redirect kills anything younger, both at issue and while in the execute stage.
    assign issueFlushed = flushValid && isOlder(flushSqN, sqN);
    assign exFlushed    = flushValid && isOlder(flushSqN, exSqN);

    assign fallThrough  = exPc + Word'(InstrBytes);
    assign branchTarget = exPc + exImm;

    always_comb begin
        aluResult = '0;
        isBranch  = 1'b0;
        taken     = 1'b0;
        case (exOp)
            OpAdd:  aluResult = exSrcA + exSrcB;
            OpSub:  aluResult = exSrcA - exSrcB;
            OpAnd:  aluResult = exSrcA & exSrcB;
            OpOr:   aluResult = exSrcA | exSrcB;
            OpXor:  aluResult = exSrcA ^ exSrcB;
            OpSll:  aluResult = exSrcA << exSrcB[4:0];
            OpSrl:  aluResult = exSrcA >> exSrcB[4:0];
            OpSra:  aluResult = $signed(exSrcA) >>> exSrcB[4:0];
            OpSlt:  aluResult = {31'b0, $signed(exSrcA) < $signed(exSrcB)};
            OpSltu: aluResult = {31'b0, exSrcA < exSrcB};
            OpBeq: begin
                isBranch = 1'b1;
                taken    = exSrcA == exSrcB;
            end
            OpBne: begin
                isBranch = 1'b1;
                taken    = exSrcA != exSrcB;
            end
            OpBlt: begin
                isBranch = 1'b1;
                taken    = $signed(exSrcA) < $signed(exSrcB);
            end
            OpBge: begin
                isBranch = 1'b1;
                taken    = $signed(exSrcA) >= $signed(exSrcB);
            end
            OpBltu: begin
                isBranch = 1'b1;
                taken    = exSrcA < exSrcB;
            end
            OpJal: begin
                // Link address goes to the destination register.
                isBranch  = 1'b1;
                taken     = 1'b1;
                aluResult = fallThrough;
            end
            default: aluResult = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exValid   <= 1'b0;
            res.valid <= 1'b0;
        end else begin
            exValid   <= issueValid && !issueFlushed;
            res.valid <= exValid && !exFlushed;
        end
    end

    always_ff @(posedge clk) begin
        exOp        <= op;
        exSrcA      <= srcA;
        exSrcB      <= srcB;
        exImm       <= imm;
        exPc        <= pc;
        exPredTaken <= predTaken;
        exTag       <= tag;
        exSqN       <= sqN;

        res.tag      <= exTag;
        res.result   <= aluResult;
        res.sqN      <= exSqN;
        res.mispred  <= isBranch && (taken != exPredTaken);
        res.targetPc <= taken ? branchTarget : fallThrough;
    end

endmodule

//--- source/BranchArbiter.sv
`timescale 1ns/1ps

module BranchArbiter import CorePkg::*; (
    input  logic  clk,
    input  logic  rst,

    ExecResultIf.arbiter res0,
    ExecResultIf.arbiter res1,

    output logic  wb0Valid,
    output RegTag wb0Tag,
    output Word   wb0Result,
    output logic  wb1Valid,
    output RegTag wb1Tag,
    output Word   wb1Result,

    output logic  redirectValid,
    output Word   redirectPc,
    output SeqNum redirectSqN
);

    logic  valid    [NumUnits];
    RegTag tag      [NumUnits];
    Word   result   [NumUnits];
    SeqNum sqN      [NumUnits];
    logic  mispred  [NumUnits];
    Word   targetPc [NumUnits];

    logic  heldSquash [NumUnits];
    logic  squash     [NumUnits];
    logic  keep       [NumUnits];

    logic  selValid;
    Word   selPc;
    SeqNum selSqN;

    assign valid[0]    = res0.valid;
    assign tag[0]      = res0.tag;
    assign result[0]   = res0.result;
    assign sqN[0]      = res0.sqN;
    assign mispred[0]  = res0.mispred;
    assign targetPc[0] = res0.targetPc;

    assign valid[1]    = res1.valid;
    assign tag[1]      = res1.tag;
    assign result[1]   = res1.result;
    assign sqN[1]      = res1.sqN;
    assign mispred[1]  = res1.mispred;
    assign targetPc[1] = res1.targetPc;

    // Pick the oldest mispredict that the held redirect has not already killed.
    always_comb begin
        selValid = 1'b0;
        selPc    = '0;
        selSqN   = '0;
        for (int i = 0; i < NumUnits; i++) begin
            heldSquash[i] = redirectValid && isOlder(redirectSqN, sqN[i]);
            if (valid[i] && mispred[i] && !heldSquash[i] &&
                (!selValid || isOlder(sqN[i], selSqN))) begin
                selValid = 1'b1;
                selPc    = targetPc[i];
                selSqN   = sqN[i];
            end
        end
    end

    // The selected branch itself still writes back; only younger results die.
    always_comb begin
        for (int i = 0; i < NumUnits; i++) begin
            squash[i] = heldSquash[i] || (selValid && isOlder(selSqN, sqN[i]));
            keep[i]   = valid[i] && (tag[i] != '0) && !squash[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb0Valid      <= 1'b0;
            wb1Valid      <= 1'b0;
            redirectValid <= 1'b0;
        end else begin
            wb0Valid      <= keep[0];
            wb1Valid      <= keep[1];
            redirectValid <= selValid;
        end
    end

    always_ff @(posedge clk) begin
        wb0Tag      <= tag[0];
        wb0Result   <= result[0];
        wb1Tag      <= tag[1];
        wb1Result   <= result[1];
        redirectPc  <= selPc;
        redirectSqN <= selSqN;
    end

endmodule

//--- source/ExecCluster.sv
`timescale 1ns/1ps

module ExecCluster import CorePkg::*, AluPkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  logic  uop0Valid,
    input  AluOp  uop0Op,
    input  Word   uop0SrcA,
    input  Word   uop0SrcB,
    input  Word   uop0Imm,
    input  Word   uop0Pc,
    input  logic  uop0PredTaken,
    input  RegTag uop0Tag,
    input  SeqNum uop0SqN,

    input  logic  uop1Valid,
    input  AluOp  uop1Op,
    input  Word   uop1SrcA,
    input  Word   uop1SrcB,
    input  Word   uop1Imm,
    input  Word   uop1Pc,
    input  logic  uop1PredTaken,
    input  RegTag uop1Tag,
    input  SeqNum uop1SqN,

    output logic  wb0Valid,
    output RegTag wb0Tag,
    output Word   wb0Result,
    output logic  wb1Valid,
    output RegTag wb1Tag,
    output Word   wb1Result,

    output logic  redirectValid,
    output Word   redirectPc,
    output SeqNum redirectSqN
);

    ExecResultIf res0If ();
    ExecResultIf res1If ();

    // The registered redirect doubles as the flush for both units.
    IntAlu intAlu0 (
        .clk        (clk),
        .rst        (rst),
        .issueValid (uop0Valid),
        .op         (uop0Op),
        .srcA       (uop0SrcA),
        .srcB       (uop0SrcB),
        .imm        (uop0Imm),
        .pc         (uop0Pc),
        .predTaken  (uop0PredTaken),
        .tag        (uop0Tag),
        .sqN        (uop0SqN),
        .flushValid (redirectValid),
        .flushSqN   (redirectSqN),
        .res        (res0If.unit)
    );

    IntAlu intAlu1 (
        .clk        (clk),
        .rst        (rst),
        .issueValid (uop1Valid),
        .op         (uop1Op),
        .srcA       (uop1SrcA),
        .srcB       (uop1SrcB),
        .imm        (uop1Imm),
        .pc         (uop1Pc),
        .predTaken  (uop1PredTaken),
        .tag        (uop1Tag),
        .sqN        (uop1SqN),
        .flushValid (redirectValid),
        .flushSqN   (redirectSqN),
        .res        (res1If.unit)
    );

    BranchArbiter branchArbiter (
        .clk           (clk),
        .rst           (rst),
        .res0          (res0If.arbiter),
        .res1          (res1If.arbiter),
        .wb0Valid      (wb0Valid),
        .wb0Tag        (wb0Tag),
        .wb0Result     (wb0Result),
        .wb1Valid      (wb1Valid),
        .wb1Tag        (wb1Tag),
        .wb1Result     (wb1Result),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .redirectSqN   (redirectSqN)
    );

endmodule

//--- testbench/ExecClusterTb.sv
`timescale 1ns/1ps

module ExecClusterTb import CorePkg::*, AluPkg::*; ();

    typedef struct packed {
        logic  valid;
        AluOp  op;
        Word   srcA;
        Word   srcB;
        Word   imm;
        Word   pc;
        logic  predTaken;
        RegTag tag;
        SeqNum sqN;
    } Uop;

    typedef struct packed {
        logic  wb0Valid;
        RegTag wb0Tag;
        Word   wb0Result;
        logic  wb1Valid;
        RegTag wb1Tag;
        Word   wb1Result;
        logic  redirectValid;
        Word   redirectPc;
        SeqNum redirectSqN;
    } Outputs;

    localparam Uop     NoUop = '0;
    localparam Outputs Quiet = '0;

    logic  clk;
    logic  rst;
    logic  uop0Valid, uop0PredTaken, uop1Valid, uop1PredTaken;
    AluOp  uop0Op, uop1Op;
    Word   uop0SrcA, uop0SrcB, uop0Imm, uop0Pc;
    Word   uop1SrcA, uop1SrcB, uop1Imm, uop1Pc;
    RegTag uop0Tag, uop1Tag;
    SeqNum uop0SqN, uop1SqN;
    logic  wb0Valid, wb1Valid, redirectValid;
    RegTag wb0Tag, wb1Tag;
    Word   wb0Result, wb1Result, redirectPc;
    SeqNum redirectSqN;

    string  rowName[$];
    Uop     row0[$];
    Uop     row1[$];
    Outputs rowExp[$];

    int cycleCount = 0;
    int cycleLimit = 1000;

    ExecCluster ExecCluster_inst (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the stimulus loop never finished", cycleCount);
            $display("Some tests failed");
            $fatal(1, "Timeout");
        end
    end

    function automatic Uop branchUop(AluOp op, Word a, Word b, Word imm, Word pc, int pred,
                                     Word tag, Word sqN);
        Uop u;
        u.valid     = 1'b1;
        u.op        = op;
        u.srcA      = a;
        u.srcB      = b;
        u.imm       = imm;
        u.pc        = pc;
        u.predTaken = pred != 0;
        u.tag       = RegTag'(tag);
        u.sqN       = SeqNum'(sqN);
        return u;
    endfunction

    function automatic Uop aluUop(AluOp op, Word a, Word b, Word tag, Word sqN);
        return branchUop(op, a, b, 0, 0, 0, tag, sqN);
    endfunction

    function automatic Outputs makeOutputs(int v0, Word t0, Word r0, int v1, Word t1, Word r1,
                                           int rv, Word rpc, Word rsq);
        Outputs o;
        o.wb0Valid      = v0 != 0;
        o.wb0Tag        = RegTag'(t0);
        o.wb0Result     = r0;
        o.wb1Valid      = v1 != 0;
        o.wb1Tag        = RegTag'(t1);
        o.wb1Result     = r1;
        o.redirectValid = rv != 0;
        o.redirectPc    = rpc;
        o.redirectSqN   = SeqNum'(rsq);
        return o;
    endfunction

    task automatic addRow(input string name, input Uop s0, input Uop s1, input Outputs e);
        rowName.push_back(name);
        row0.push_back(s0);
        row1.push_back(s1);
        rowExp.push_back(e);
    endtask

    task automatic driveSlots(input Uop s0, input Uop s1);
        uop0Valid     = s0.valid;
        uop0Op        = s0.op;
        uop0SrcA      = s0.srcA;
        uop0SrcB      = s0.srcB;
        uop0Imm       = s0.imm;
        uop0Pc        = s0.pc;
        uop0PredTaken = s0.predTaken;
        uop0Tag       = s0.tag;
        uop0SqN       = s0.sqN;
        uop1Valid     = s1.valid;
        uop1Op        = s1.op;
        uop1SrcA      = s1.srcA;
        uop1SrcB      = s1.srcB;
        uop1Imm       = s1.imm;
        uop1Pc        = s1.pc;
        uop1PredTaken = s1.predTaken;
        uop1Tag       = s1.tag;
        uop1SqN       = s1.sqN;
    endtask

    task automatic compareField(input string testName, input string field, input Word expVal,
                                input Word actVal);
        assert (actVal === expVal) else begin
            $display("Error %s %s expected 0x%08h actual 0x%08h",
                     testName, field, expVal, actVal);
            $display("Some tests failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    // Tag, data and redirect fields are only compared when their valid is expected high.
    task automatic checkOutputs(input string testName, input Outputs e);
        compareField(testName, "wb0Valid", 32'(e.wb0Valid), 32'(wb0Valid));
        compareField(testName, "wb1Valid", 32'(e.wb1Valid), 32'(wb1Valid));
        compareField(testName, "redirectValid", 32'(e.redirectValid), 32'(redirectValid));
        if (e.wb0Valid) begin
            compareField(testName, "wb0Tag", 32'(e.wb0Tag), 32'(wb0Tag));
            compareField(testName, "wb0Result", e.wb0Result, wb0Result);
        end
        if (e.wb1Valid) begin
            compareField(testName, "wb1Tag", 32'(e.wb1Tag), 32'(wb1Tag));
            compareField(testName, "wb1Result", e.wb1Result, wb1Result);
        end
        if (e.redirectValid) begin
            compareField(testName, "redirectPc", e.redirectPc, redirectPc);
            compareField(testName, "redirectSqN", 32'(e.redirectSqN), 32'(redirectSqN));
        end
    endtask

    task automatic buildTable();
        addRow("aluAddSub", aluUop(OpAdd, 5, 7, 1, 0), aluUop(OpSub, 10, 3, 2, 1),
            makeOutputs(1, 1, 12, 1, 2, 7, 0, 0, 0));
        addRow("aluAndOr", aluUop(OpAnd, 32'hF0F0_FF00, 32'h0FF0_F0F0, 3, 2),
            aluUop(OpOr, 32'hF000_0000, 32'h0000_000F, 4, 3),
            makeOutputs(1, 3, 32'h00F0_F000, 1, 4, 32'hF000_000F, 0, 0, 0));
        // Shift amount 0x24 keeps only its low five bits.
        addRow("aluXorSll", aluUop(OpXor, 32'hFF00_FF00, 32'h0F0F_0F0F, 5, 4),
            aluUop(OpSll, 3, 32'h24, 6, 5),
            makeOutputs(1, 5, 32'hF00F_F00F, 1, 6, 32'h30, 0, 0, 0));
        addRow("aluSrlSra", aluUop(OpSrl, 32'h8000_0010, 4, 7, 6),
            aluUop(OpSra, 32'h8000_0010, 4, 8, 7),
            makeOutputs(1, 7, 32'h0800_0001, 1, 8, 32'hF800_0001, 0, 0, 0));
        addRow("aluSltSltu", aluUop(OpSlt, 32'hFFFF_FFFF, 1, 9, 8),
            aluUop(OpSltu, 32'hFFFF_FFFF, 1, 10, 9), makeOutputs(1, 9, 1, 1, 10, 0, 0, 0, 0));
        addRow("brBeqJal", branchUop(OpBeq, 3, 3, 32'h40, 32'h100, 1, 0, 10),
            branchUop(OpJal, 0, 0, 32'h80, 32'h200, 1, 12, 11),
            makeOutputs(0, 0, 0, 1, 12, 32'h204, 0, 0, 0));
        addRow("tagZeroBne", aluUop(OpAdd, 4, 4, 0, 12),
            branchUop(OpBne, 1, 2, 16, 32'h280, 1, 0, 13), Quiet);
        addRow("brBltBge", branchUop(OpBlt, 32'hFFFF_FFFF, 1, 8, 32'h180, 1, 0, 14),
            branchUop(OpBge, 1, 32'hFFFF_FFFF, 8, 32'h184, 1, 0, 15), Quiet);
        addRow("brBltuAdd", branchUop(OpBltu, 32'hFFFF_FFFF, 1, 8, 32'h188, 0, 0, 16),
            aluUop(OpAdd, 1, 1, 13, 17), makeOutputs(0, 0, 0, 1, 13, 2, 0, 0, 0));
        addRow("mispredBne", branchUop(OpBne, 5, 5, 32'h20, 32'h300, 1, 0, 18), NoUop,
            makeOutputs(0, 0, 0, 0, 0, 0, 1, 32'h304, 18));
        repeat (3) addRow("redirectPulse", NoUop, NoUop, Quiet);
        // Sequence 63 is older than 0 across the wrap, so the jal in slot 0 dies.
        addRow("bothMispredWrap", branchUop(OpJal, 0, 0, 32'h20, 32'h400, 0, 14, 0),
            branchUop(OpBlt, 1, 2, 32'h10, 32'h3FC, 0, 0, 63),
            makeOutputs(0, 0, 0, 0, 0, 0, 1, 32'h40C, 63));
        repeat (3) addRow("drainWrap", NoUop, NoUop, Quiet);
        addRow("squashSameRow", branchUop(OpBge, 7, 7, 32'h100, 32'h500, 0, 0, 20),
            aluUop(OpAdd, 2, 3, 15, 21), makeOutputs(0, 0, 0, 0, 0, 0, 1, 32'h600, 20));
        addRow("squashNextRow", aluUop(OpOr, 32'h0F, 32'hF0, 16, 19),
            aluUop(OpSub, 9, 1, 17, 22), makeOutputs(1, 16, 32'hFF, 0, 0, 0, 0, 0, 0));
        addRow("squashExStage", aluUop(OpXor, 1, 3, 18, 23), aluUop(OpAdd, 1, 2, 19, 18),
            makeOutputs(0, 0, 0, 1, 19, 3, 0, 0, 0));
        addRow("squashAtIssue", aluUop(OpAdd, 5, 5, 22, 24), NoUop, Quiet);
        addRow("afterRedirect", aluUop(OpAdd, 32'h10, 32'h20, 20, 25), NoUop,
            makeOutputs(1, 20, 32'h30, 0, 0, 0, 0, 0, 0));
        addRow("olderSameRow", aluUop(OpSub, 9, 4, 21, 26),
            branchUop(OpBltu, 1, 2, 8, 32'h700, 0, 0, 27),
            makeOutputs(1, 21, 5, 0, 0, 0, 1, 32'h708, 27));
        repeat (3) addRow("drainTail", NoUop, NoUop, Quiet);
    endtask

    initial begin
        rst = 1'b1;
        driveSlots(NoUop, NoUop);
        buildTable();
        cycleLimit = 8 + rowName.size() + 10;

        repeat (8) begin
            @(posedge clk);
            #1;
            checkOutputs("reset", Quiet);
        end
        rst = 1'b0;

        // Results leave the cluster three rows after they are driven.
        for (int j = 0; j < rowName.size(); j++) begin
            @(posedge clk);
            #1;
            if (j >= 3) begin
                checkOutputs(rowName[j - 3], rowExp[j - 3]);
            end else begin
                checkOutputs("postReset", Quiet);
            end
            driveSlots(row0[j], row1[j]);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

//--- sim.f
source/CorePkg.sv
source/AluPkg.sv
source/ExecResultIf.sv
source/IntAlu.sv
source/BranchArbiter.sv
source/ExecCluster.sv
testbench/ExecClusterTb.sv

//--- Makefile
# Verilator build and run for the execute cluster testbench.

VERILATOR ?= verilator
TOP       ?= ExecClusterTb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench makes the binary exit nonzero, which fails this target.
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
